// File: verilog.f
+incdir+.
vld_pkg.sv
vld_insn_queue.sv
vld_beat_packer.sv
vld_result_queue.sv
vld_top.sv
tb_vld_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the load unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f verilog.f --top-module tb_vld_top -o sim_vld

./obj_dir/sim_vld > sim.log
cat sim.log

if grep -qx "PASS: all tests" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: tb_vld_top.sv
`timescale 1ns/10ps

`include "vld_settings.svh"

module tb_vld_top import vld_pkg::*; ();

  localparam int NrLanes   = `VLD_NR_LANES;
  localparam int LaneBytes = `VLD_ELEN / 8;
  localparam int WordBytes = `VLD_WORD_BYTES;
  localparam int Timeout   = 5000;

  // One register-file word as the lanes should see it
  typedef struct packed {
    vid_t                       id;
    vaddr_t [`VLD_NR_LANES-1:0] addr;
    elen_t  [`VLD_NR_LANES-1:0] wdata;
    strb_t  [`VLD_NR_LANES-1:0] be;
  } word_t;

  logic                 clk;
  logic                 rst_n;
  logic                 req_valid;
  vid_t                 req_id;
  vlen_t                req_vl;
  eew_t                 req_eew;
  vreg_t                req_vd;
  logic                 req_ready;
  logic                 r_valid;
  beat_t                r_data;
  logic                 r_ready;
  logic   [NrLanes-1:0] result_req;
  vid_t   [NrLanes-1:0] result_id;
  vaddr_t [NrLanes-1:0] result_addr;
  elen_t  [NrLanes-1:0] result_wdata;
  strb_t  [NrLanes-1:0] result_be;
  logic   [NrLanes-1:0] result_gnt;
  logic   [NrLanes-1:0] gnt_en;
  logic                 done;
  vid_t                 done_id;

  int seed = 32'hb12d_73d5;

  // Model state updated on the falling edge
  insn_t iss_q [$];
  int    iss_word;
  word_t exp_words [$];
  int    granted [NrLanes];
  vid_t  acc_ids [$];
  int    done_end [$];
  int    cmp_cycle [$];
  int    total_words;
  int    beats_owed;
  int    done_cnt;
  int    cycle;
  int    errors;
  int    tests_run;
  int    tests_ok;
  // Stimulus knobs
  int    beat_gap_pct;
  int    gnt_stall_pct;
  logic  beat_en;
  logic  beat_fire;
  vid_t  next_id;

  vld_top i_vld_top (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .req_valid_i    (req_valid),
    .req_id_i       (req_id),
    .req_vl_i       (req_vl),
    .req_eew_i      (req_eew),
    .req_vd_i       (req_vd),
    .req_ready_o    (req_ready),
    .r_valid_i      (r_valid),
    .r_data_i       (r_data),
    .r_ready_o      (r_ready),
    .result_req_o   (result_req),
    .result_id_o    (result_id),
    .result_addr_o  (result_addr),
    .result_wdata_o (result_wdata),
    .result_be_o    (result_be),
    .result_gnt_i   (result_gnt),
    .done_o         (done),
    .done_id_o      (done_id)
  );

  // Lanes only grant a pending request
  assign result_gnt = result_req & gnt_en;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Random grant stalls per lane
  always @(posedge clk) begin
    for (int l = 0; l < NrLanes; l++) begin
      gnt_en[l] <= ($unsigned($random(seed)) % 100) >= gnt_stall_pct;
    end
  end

  // Beat source holds each beat until it is taken
  always @(posedge clk) begin
    if (!r_valid || beat_fire) begin
      if (beat_en && beats_owed > 0 && ($unsigned($random(seed)) % 100) >= beat_gap_pct) begin
        r_valid    <= 1'b1;
        r_data     <= {$random(seed), $random(seed), $random(seed), $random(seed)};
        beats_owed = beats_owed - 1;
      end else begin
        r_valid <= 1'b0;
      end
    end
  end

  // Monitor and model sample on the falling edge where all signals are stable
  always @(negedge clk) begin
    beat_fire = r_valid && r_ready;
    if (rst_n) begin
      if (done) check_done();
      for (int l = 0; l < NrLanes; l++) begin
        if (result_req[l] && result_gnt[l]) check_lane(l);
      end
      // Note each load whose last word is now written on every lane
      while (cmp_cycle.size() < done_end.size() &&
             min_granted() >= done_end[cmp_cycle.size()]) begin
        cmp_cycle.push_back(cycle);
      end
      if (beat_fire) model_beat(r_data);
      if (req_valid && req_ready) model_accept();
    end
    cycle++;
  end

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic abort_run(input string what);
    $display("ERROR t=%0t timeout, %s", $time, what);
    $display("FAIL: see errors above");
    $finish;
  endtask

  function automatic int min_granted();
    int m;
    m = granted[0];
    for (int l = 1; l < NrLanes; l++) begin
      if (granted[l] < m) m = granted[l];
    end
    return m;
  endfunction

  task automatic model_accept();
    insn_t insn;
    int    words;
    insn.id  = req_id;
    insn.vl  = req_vl;
    insn.eew = req_eew;
    insn.vd  = req_vd;
    // Words per load are the total bytes rounded up to whole words
    words = ((int'(req_vl) << req_eew) + WordBytes - 1) / WordBytes;
    total_words += words;
    iss_q.push_back(insn);
    acc_ids.push_back(req_id);
    done_end.push_back(total_words);
    beats_owed += words;
  endtask

  task automatic model_beat(input beat_t beat);
    word_t w;
    int    bytes;
    int    pos;
    if (iss_q.size() == 0) begin
      $display("ERROR t=%0t beat taken with no load waiting for issue", $time);
      errors++;
    end else begin
      bytes = int'(iss_q[0].vl) << iss_q[0].eew;
      w.id  = iss_q[0].id;
      for (int l = 0; l < NrLanes; l++) begin
        w.addr[l]  = vaddr_t'(int'(iss_q[0].vd) * `VLD_REG_WORDS + iss_word);
        // Lane 0 gets the lowest bytes of the beat
        w.wdata[l] = beat[`VLD_ELEN*l +: `VLD_ELEN];
        for (int b = 0; b < LaneBytes; b++) begin
          pos = iss_word * WordBytes + l * LaneBytes + b;
          w.be[l][b] = (pos < bytes);
        end
      end
      exp_words.push_back(w);
      iss_word++;
      if (iss_word * WordBytes >= bytes) begin
        iss_q.pop_front();
        iss_word = 0;
      end
    end
  endtask

  task automatic check_lane(input int l);
    word_t w;
    if (granted[l] >= exp_words.size()) begin
      $display("ERROR t=%0t lane %0d wrote a word that was never loaded", $time, l);
      errors++;
    end else begin
      w = exp_words[granted[l]];
      check_value($sformatf("result_id_o[%0d]", l), 64'(result_id[l]), 64'(w.id));
      check_value($sformatf("result_addr_o[%0d]", l), 64'(result_addr[l]), 64'(w.addr[l]));
      check_value($sformatf("result_wdata_o[%0d]", l), result_wdata[l], w.wdata[l]);
      check_value($sformatf("result_be_o[%0d]", l), 64'(result_be[l]), 64'(w.be[l]));
    end
    granted[l]++;
  endtask

  task automatic check_done();
    int k;
    k = done_cnt;
    if (k >= acc_ids.size()) begin
      $display("ERROR t=%0t done pulse with no load outstanding", $time);
      errors++;
    end else begin
      check_value("done_id_o", 64'(done_id), 64'(acc_ids[k]));
      if (k >= cmp_cycle.size()) begin
        $display("ERROR t=%0t done pulse before the last word was granted", $time);
        errors++;
      end else if (cmp_cycle[k] != cycle - 1) begin
        $display("ERROR t=%0t done pulse %0d cycles after the final grant", $time,
                 cycle - cmp_cycle[k]);
        errors++;
      end
    end
    done_cnt++;
  endtask

  task automatic send_insn(input vlen_t vl, input eew_t eew, input vreg_t vd, input logic last);
    int t;
    @(posedge clk);
    req_valid <= 1'b1;
    req_id    <= next_id;
    req_vl    <= vl;
    req_eew   <= eew;
    req_vd    <= vd;
    t = 0;
    @(negedge clk);
    while (!(req_valid && req_ready) && t < Timeout) begin
      @(negedge clk);
      t++;
    end
    if (!(req_valid && req_ready)) abort_run("load never accepted by the unit");
    next_id++;
    // Drop valid unless another load follows back to back
    if (last) begin
      @(posedge clk);
      req_valid <= 1'b0;
    end
  endtask

  task automatic random_insn(input logic last);
    eew_t  eew;
    vlen_t vl;
    eew = eew_t'($unsigned($random(seed)) % 4);
    vl  = vlen_t'(1 + ($unsigned($random(seed)) % (128 >> eew)));
    send_insn(vl, eew, vreg_t'($random(seed)), last);
  endtask

  function automatic logic drained();
    logic ok;
    ok = (done_cnt >= acc_ids.size()) && (beats_owed == 0);
    for (int l = 0; l < NrLanes; l++) begin
      ok = ok && (granted[l] == exp_words.size());
    end
    return ok;
  endfunction

  task automatic wait_drain();
    int t;
    t = 0;
    while (!drained() && t < 4 * Timeout) begin
      @(posedge clk);
      t++;
    end
    if (!drained()) abort_run("outstanding loads did not finish");
    @(negedge clk);
  endtask

  task automatic finish_test(input string name, input int start);
    tests_run++;
    if (errors == start) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - start);
    end
  endtask

  initial begin
    int    start;
    int    base;
    int    t;
    vlen_t vl;
    req_valid     = 1'b0;
    req_id        = '0;
    req_vl        = '0;
    req_eew       = '0;
    req_vd        = '0;
    r_valid       = 1'b0;
    r_data        = '0;
    gnt_en        = '0;
    beat_en       = 1'b0;
    beat_fire     = 1'b0;
    beat_gap_pct  = 0;
    gnt_stall_pct = 0;
    next_id       = '0;
    rst_n         = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // Idle outputs right after reset
    start = errors;
    @(negedge clk);
    check_value("req_ready_o", 64'(req_ready), 64'd1);
    check_value("r_ready_o", 64'(r_ready), 64'd0);
    check_value("result_req_o", 64'(result_req), 64'd0);
    check_value("done_o", 64'(done), 64'd0);
    finish_test("reset state", start);

    // One load per element width that always ends in a partial tail word
    start   = errors;
    beat_en = 1'b1;
    for (int e = 0; e < 4; e++) begin
      vl = vlen_t'(1 + ($unsigned($random(seed)) % (128 >> e)));
      if (((int'(vl) << e) % WordBytes) == 0 && vl > 8'd1) vl = vl - 8'd1;
      send_insn(vl, eew_t'(e), vreg_t'($random(seed)), 1'b1);
      wait_drain();
    end
    finish_test("data packing", start);

    // Fill the queue without beats and then free one slot
    start   = errors;
    beat_en = 1'b0;
    for (int i = 0; i < `VLD_INSN_DEPTH; i++) begin
      random_insn(i == `VLD_INSN_DEPTH - 1);
    end
    @(negedge clk);
    check_value("req_ready_o", 64'(req_ready), 64'd0);
    base    = done_cnt;
    beat_en = 1'b1;
    t       = 0;
    while (done_cnt == base && t < 4 * Timeout) begin
      @(posedge clk);
      t++;
    end
    if (done_cnt == base) abort_run("no done pulse after beats resumed");
    random_insn(1'b1);
    wait_drain();
    finish_test("queue depth", start);

    // Stalled lanes and gaps between beats
    start         = errors;
    beat_gap_pct  = 40;
    gnt_stall_pct = 50;
    for (int i = 0; i < 8; i++) begin
      random_insn(1'b1);
    end
    wait_drain();
    finish_test("back-pressure", start);

    // Long streamed run expects one done pulse per load in order
    start         = errors;
    base          = done_cnt;
    beat_gap_pct  = 30;
    gnt_stall_pct = 30;
    for (int i = 0; i < 20; i++) begin
      random_insn(i == 19);
    end
    wait_drain();
    if (done_cnt - base != 20) begin
      $display("ERROR t=%0t saw %0d done pulses for 20 loads", $time, done_cnt - base);
      errors++;
    end
    finish_test("done reporting", start);

    $display("tests passed %0d of %0d, errors %0d", tests_ok, tests_run, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: vld_top.sv
`timescale 1ns/10ps

`include "vld_settings.svh"

module vld_top import vld_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Sequencer
  input  logic                         req_valid_i,
  input  vid_t                         req_id_i,
  input  vlen_t                        req_vl_i,
  input  eew_t                         req_eew_i,
  input  vreg_t                        req_vd_i,
  output logic                         req_ready_o,
  // Read channel
  input  logic                         r_valid_i,
  input  beat_t                        r_data_i,
  output logic                         r_ready_o,
  // Lanes
  output logic   [`VLD_NR_LANES-1:0]   result_req_o,
  output vid_t   [`VLD_NR_LANES-1:0]   result_id_o,
  output vaddr_t [`VLD_NR_LANES-1:0]   result_addr_o,
  output elen_t  [`VLD_NR_LANES-1:0]   result_wdata_o,
  output strb_t  [`VLD_NR_LANES-1:0]   result_be_o,
  input  logic   [`VLD_NR_LANES-1:0]   result_gnt_i,
  // Retirement
  output logic                         done_o,
  output vid_t                         done_id_o
);

  insn_t                        issue_insn;
  logic                         issue_valid;
  insn_t                        commit_insn;
  logic                         commit_valid;
  logic                         issue_done;
  logic                         commit_done;
  logic                         full;
  // Word from packer to result queue
  logic                         word_push;
  vid_t                         push_id;
  vaddr_t [`VLD_NR_LANES-1:0]   push_addr;
  elen_t  [`VLD_NR_LANES-1:0]   push_wdata;
  strb_t  [`VLD_NR_LANES-1:0]   push_be;

  vld_insn_queue i_insn_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_id_i       (req_id_i),
    .req_vl_i       (req_vl_i),
    .req_eew_i      (req_eew_i),
    .req_vd_i       (req_vd_i),
    .req_ready_o    (req_ready_o),
    .issue_done_i   (issue_done),
    .commit_done_i  (commit_done),
    .issue_insn_o   (issue_insn),
    .issue_valid_o  (issue_valid),
    .commit_insn_o  (commit_insn),
    .commit_valid_o (commit_valid),
    .done_o         (done_o),
    .done_id_o      (done_id_o)
  );

  vld_beat_packer i_beat_packer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .r_valid_i     (r_valid_i),
    .r_data_i      (r_data_i),
    .r_ready_o     (r_ready_o),
    .issue_insn_i  (issue_insn),
    .issue_valid_i (issue_valid),
    .full_i        (full),
    .issue_done_o  (issue_done),
    .push_o        (word_push),
    .push_id_o     (push_id),
    .push_addr_o   (push_addr),
    .push_wdata_o  (push_wdata),
    .push_be_o     (push_be)
  );

  vld_result_queue i_result_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (word_push),
    .push_id_i      (push_id),
    .push_addr_i    (push_addr),
    .push_wdata_i   (push_wdata),
    .push_be_i      (push_be),
    .full_o         (full),
    .commit_insn_i  (commit_insn),
    .commit_valid_i (commit_valid),
    .commit_done_o  (commit_done),
    .result_req_o   (result_req_o),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i)
  );

endmodule

// File: vld_result_queue.sv
`timescale 1ns/10ps

`include "vld_settings.svh"

module vld_result_queue import vld_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Word from the packer
  input  logic                         push_i,
  input  vid_t                         push_id_i,
  input  vaddr_t [`VLD_NR_LANES-1:0]   push_addr_i,
  input  elen_t  [`VLD_NR_LANES-1:0]   push_wdata_i,
  input  strb_t  [`VLD_NR_LANES-1:0]   push_be_i,
  output logic                         full_o,
  // Commit head from the instruction queue
  input  insn_t                        commit_insn_i,
  input  logic                         commit_valid_i,
  output logic                         commit_done_o,
  // Lane write ports
  output logic   [`VLD_NR_LANES-1:0]   result_req_o,
  output vid_t   [`VLD_NR_LANES-1:0]   result_id_o,
  output vaddr_t [`VLD_NR_LANES-1:0]   result_addr_o,
  output elen_t  [`VLD_NR_LANES-1:0]   result_wdata_o,
  output strb_t  [`VLD_NR_LANES-1:0]   result_be_o,
  input  logic   [`VLD_NR_LANES-1:0]   result_gnt_i
);

  localparam int unsigned NrLanes   = `VLD_NR_LANES;
  localparam int unsigned Depth     = `VLD_RESULT_DEPTH;
  localparam int unsigned WordBytes = `VLD_WORD_BYTES;
  localparam int unsigned PntW      = $clog2(Depth);

  // Payload per entry
  vid_t                   id_q    [Depth];
  vaddr_t [NrLanes-1:0]   addr_q  [Depth];
  elen_t  [NrLanes-1:0]   wdata_q [Depth];
  strb_t  [NrLanes-1:0]   be_q    [Depth];
  // One pending bit per entry and lane
  logic [Depth-1:0][NrLanes-1:0] valid_q;

  logic [PntW-1:0] wr_pnt_q;
  logic [PntW-1:0] rd_pnt_q;
  logic [PntW:0]   cnt_q;

  vlen_t            ccnt_q;
  logic             loaded_q;
  vlen_t            cur_cnt;
  vlen_t            word_elems;
  vlen_t            ccnt_d;
  logic [NrLanes-1:0] head_left;
  logic             pop;

  assign full_o = (cnt_q == (PntW+1)'(Depth));

  // Lanes still owing a grant after this cycle
  assign head_left = valid_q[rd_pnt_q] & ~result_gnt_i;
  // Head leaves with its last outstanding grant
  assign pop       = (cnt_q != '0) && (head_left == '0);

  assign result_req_o = valid_q[rd_pnt_q];
  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      result_id_o[l]    = id_q[rd_pnt_q];
      result_addr_o[l]  = addr_q[rd_pnt_q][l];
      result_wdata_o[l] = wdata_q[rd_pnt_q][l];
      result_be_o[l]    = be_q[rd_pnt_q][l];
    end
  end

  // Elements still to be written for the commit head
  assign cur_cnt    = loaded_q ? ccnt_q : commit_insn_i.vl;
  assign word_elems = vlen_t'(WordBytes) >> commit_insn_i.eew;
  assign ccnt_d     = (cur_cnt > word_elems) ? cur_cnt - word_elems : '0;

  assign commit_done_o = pop && commit_valid_i && (ccnt_d == '0);

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      id_q[wr_pnt_q]    <= push_id_i;
      addr_q[wr_pnt_q]  <= push_addr_i;
      wdata_q[wr_pnt_q] <= push_wdata_i;
      be_q[wr_pnt_q]    <= push_be_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
      ccnt_q   <= '0;
      loaded_q <= 1'b0;
    end else begin
      // Grants clear lanes of the head
      if (cnt_q != '0) begin
        valid_q[rd_pnt_q] <= head_left;
      end
      // New word requests on every lane
      if (push_i) begin
        valid_q[wr_pnt_q] <= '1;
        wr_pnt_q          <= (wr_pnt_q == PntW'(Depth - 1)) ? '0 : wr_pnt_q + 1'b1;
      end
      if (pop) begin
        rd_pnt_q <= (rd_pnt_q == PntW'(Depth - 1)) ? '0 : rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + {{PntW{1'b0}}, push_i} - {{PntW{1'b0}}, pop};
      if (pop && commit_valid_i) begin
        ccnt_q   <= ccnt_d;
        loaded_q <= !commit_done_o;
      end
    end
  end

  // The packer honours full, so the queue never overflows
  a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= (PntW+1)'(Depth));

  // Lanes grant only what is requested
  a_gnt_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (result_gnt_i & ~result_req_o) == '0);

endmodule

// File: vld_beat_packer.sv
`timescale 1ns/10ps

`include "vld_settings.svh"

module vld_beat_packer import vld_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Read channel
  input  logic                         r_valid_i,
  input  beat_t                        r_data_i,
  output logic                         r_ready_o,
  // Issue head from the instruction queue
  input  insn_t                        issue_insn_i,
  input  logic                         issue_valid_i,
  // Result queue back-pressure
  input  logic                         full_i,
  output logic                         issue_done_o,
  // Word going into the result queue
  output logic                         push_o,
  output vid_t                         push_id_o,
  output vaddr_t [`VLD_NR_LANES-1:0]   push_addr_o,
  output elen_t  [`VLD_NR_LANES-1:0]   push_wdata_o,
  output strb_t  [`VLD_NR_LANES-1:0]   push_be_o
);

  localparam int unsigned NrLanes   = `VLD_NR_LANES;
  localparam int unsigned LaneBytes = `VLD_ELEN / 8;
  localparam int unsigned WordBytes = `VLD_WORD_BYTES;
  localparam int unsigned IdxW      = $clog2(`VLD_REG_WORDS);
  // Wide enough for vl shifted by the largest element size
  localparam int unsigned ByteW     = $bits(vlen_t) + 3;

  vlen_t            cnt_q;
  logic             loaded_q;
  logic [IdxW-1:0]  word_idx_q;

  vlen_t            cur_cnt;
  vlen_t            word_elems;
  vlen_t            cnt_d;
  logic [ByteW-1:0] vl_bytes;
  logic [ByteW-1:0] word_base;
  vaddr_t           word_addr;
  logic             beat;

  // Take a beat only with an instruction to issue and room downstream
  assign r_ready_o = issue_valid_i && !full_i;
  assign beat      = r_valid_i && r_ready_o;

  // Fresh head starts from its full vl
  assign cur_cnt    = loaded_q ? cnt_q : issue_insn_i.vl;
  assign word_elems = vlen_t'(WordBytes) >> issue_insn_i.eew;
  assign cnt_d      = (cur_cnt > word_elems) ? cur_cnt - word_elems : '0;

  assign issue_done_o = beat && (cnt_d == '0);

  assign vl_bytes  = ByteW'(issue_insn_i.vl) << issue_insn_i.eew;
  assign word_base = ByteW'(word_idx_q) * ByteW'(WordBytes);
  // Register number selects a block of words, index picks one
  assign word_addr = vaddr_t'(issue_insn_i.vd) * vaddr_t'(`VLD_REG_WORDS) + vaddr_t'(word_idx_q);

  assign push_o    = beat;
  assign push_id_o = issue_insn_i.id;

  // Bytes go to lanes in order, lane 0 takes the lowest bytes
  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      push_addr_o[l]  = word_addr;
      push_wdata_o[l] = r_data_i[`VLD_ELEN*l +: `VLD_ELEN];
      for (int b = 0; b < LaneBytes; b++) begin
        // Tail bytes past vl are masked off
        push_be_o[l][b] = (word_base + ByteW'(l * LaneBytes + b)) < vl_bytes;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q      <= '0;
      loaded_q   <= 1'b0;
      word_idx_q <= '0;
    end else if (beat) begin
      cnt_q      <= cnt_d;
      // Next head reloads its own count
      loaded_q   <= !issue_done_o;
      word_idx_q <= issue_done_o ? '0 : word_idx_q + 1'b1;
    end
  end

endmodule

// File: vld_insn_queue.sv
`timescale 1ns/10ps

`include "vld_settings.svh"

module vld_insn_queue import vld_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  // Sequencer
  input  logic  req_valid_i,
  input  vid_t  req_id_i,
  input  vlen_t req_vl_i,
  input  eew_t  req_eew_i,
  input  vreg_t req_vd_i,
  output logic  req_ready_o,
  // Strobes back from the datapath
  input  logic  issue_done_i,
  input  logic  commit_done_i,
  // Heads of the issue and commit phases
  output insn_t issue_insn_o,
  output logic  issue_valid_o,
  output insn_t commit_insn_o,
  output logic  commit_valid_o,
  // Retirement report
  output logic  done_o,
  output vid_t  done_id_o
);

  localparam int unsigned Depth = `VLD_INSN_DEPTH;
  localparam int unsigned PntW  = $clog2(Depth);

  // Circular buffer written at accept and read at issue and commit
  insn_t insn_q [Depth];

  logic [PntW-1:0] accept_pnt_q;
  logic [PntW-1:0] issue_pnt_q;
  logic [PntW-1:0] commit_pnt_q;
  // Waiting for issue is a subset of waiting for commit
  logic [PntW:0]   issue_cnt_q;
  logic [PntW:0]   commit_cnt_q;

  insn_t req_insn;
  logic  full;
  logic  accept;

  assign req_insn.id  = req_id_i;
  assign req_insn.vl  = req_vl_i;
  assign req_insn.eew = req_eew_i;
  assign req_insn.vd  = req_vd_i;

  // An entry stays busy until its last word has been written
  assign full        = (commit_cnt_q == (PntW+1)'(Depth));
  assign req_ready_o = !full;
  assign accept      = req_valid_i && !full;

  assign issue_insn_o   = insn_q[issue_pnt_q];
  assign issue_valid_o  = (issue_cnt_q != '0);
  assign commit_insn_o  = insn_q[commit_pnt_q];
  assign commit_valid_o = (commit_cnt_q != '0);

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= req_insn;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      done_o       <= 1'b0;
      done_id_o    <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= (accept_pnt_q == PntW'(Depth - 1)) ? '0 : accept_pnt_q + 1'b1;
      end
      if (issue_done_i) begin
        issue_pnt_q <= (issue_pnt_q == PntW'(Depth - 1)) ? '0 : issue_pnt_q + 1'b1;
      end
      if (commit_done_i) begin
        commit_pnt_q <= (commit_pnt_q == PntW'(Depth - 1)) ? '0 : commit_pnt_q + 1'b1;
      end
      // Accept and retire can happen in the same cycle
      issue_cnt_q  <= issue_cnt_q + {{PntW{1'b0}}, accept} - {{PntW{1'b0}}, issue_done_i};
      commit_cnt_q <= commit_cnt_q + {{PntW{1'b0}}, accept} - {{PntW{1'b0}}, commit_done_i};
      // Done pulse follows the final grant by one cycle
      done_o <= commit_done_i;
      if (commit_done_i) begin
        done_id_o <= commit_insn_o.id;
      end
    end
  end

  // Queue never holds more than its depth and commit never runs ahead of issue
  a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (commit_cnt_q <= (PntW+1)'(Depth)) && (issue_cnt_q <= commit_cnt_q));

  // The packer only finishes an instruction that was handed to it
  a_issue_done_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_done_i |-> issue_valid_o);

endmodule

// File: vld_pkg.sv
package vld_pkg;

  `include "vld_settings.svh"

  // Element width code
  // 0 is 8 bits, 1 is 16, 2 is 32, 3 is 64
  typedef logic [1:0] eew_t;

  // Instruction id
  typedef logic [$clog2(`VLD_NR_IDS)-1:0] vid_t;

  // Element count, up to 128
  typedef logic [7:0] vlen_t;

  // Destination register number
  typedef logic [4:0] vreg_t;

  // Register-file word address
  typedef logic [7:0] vaddr_t;

  // One lane word and its byte enables
  typedef logic [`VLD_ELEN-1:0]   elen_t;
  typedef logic [`VLD_ELEN/8-1:0] strb_t;

  // One read beat, a full register-file word
  typedef logic [8*`VLD_WORD_BYTES-1:0] beat_t;

  // Load instruction as held in the queue
  typedef struct packed {
    vid_t  id;
    vlen_t vl;
    eew_t  eew;
    vreg_t vd;
  } insn_t;

endpackage

// File: vld_settings.svh
`ifndef VLD_SETTINGS_SVH
`define VLD_SETTINGS_SVH

// Lanes of the vector register file
`define VLD_NR_LANES 2
// Bits in one lane word
`define VLD_ELEN 64
// Bytes in one register-file word, also the read beat width
`define VLD_WORD_BYTES (`VLD_NR_LANES * 8)

// Instruction queue depth
`define VLD_INSN_DEPTH 4
// Result queue depth, shared by all lanes
`define VLD_RESULT_DEPTH 2

// Words in one vector register
`define VLD_REG_WORDS 8
// Distinct instruction ids
`define VLD_NR_IDS 8

`endif
